// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    ///////////////////////////////////////////////////////////////////////
    // widths and sizes
    ///////////////////////////////////////////////////////////////////////

    localparam int XLEN        = 32;
    localparam int PHY_REGS    = 64;
    localparam int PHY_IDX     = 6;
    localparam int ARCH_IDX    = 5;
    localparam int ROB_IDX     = 4;
    localparam int INTRS_DEPTH = 8;
    localparam int INTRS_IDX   = 3;
    localparam int CDB_WIDTH   = 2;

    ///////////////////////////////////////////////////////////////////////
    // encodings
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM,
        OP2_ZERO
    } op2_sel_e;

    ///////////////////////////////////////////////////////////////////////
    // bundles
    ///////////////////////////////////////////////////////////////////////

    // renamed micro-op as it leaves dispatch
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        alu_op_e             fu_opcode;
        op1_sel_e            op1_sel;
        op2_sel_e            op2_sel;
        logic [PHY_IDX-1:0]  rd_phy;
        logic [ARCH_IDX-1:0] rd_arch;
        logic [PHY_IDX-1:0]  rs1_phy;
        logic                rs1_valid;
        logic [PHY_IDX-1:0]  rs2_phy;
        logic                rs2_valid;
        logic [XLEN-1:0]     imm;
        logic [ROB_IDX-1:0]  rob_id;
    } uop_t;

    // issue register, source tags replaced by operand values
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        alu_op_e             fu_opcode;
        op1_sel_e            op1_sel;
        op2_sel_e            op2_sel;
        logic [PHY_IDX-1:0]  rd_phy;
        logic [ARCH_IDX-1:0] rd_arch;
        logic [XLEN-1:0]     imm;
        logic [ROB_IDX-1:0]  rob_id;
        logic [XLEN-1:0]     rs1_value;
        logic [XLEN-1:0]     rs2_value;
    } issue_t;

    // one result broadcast
    typedef struct packed {
        logic                valid;
        logic [ROB_IDX-1:0]  rob_id;
        logic [PHY_IDX-1:0]  rd_phy;
        logic [ARCH_IDX-1:0] rd_arch;
        logic [XLEN-1:0]     value;
    } cdb_t;

endpackage

// ==== source/int_rs.sv ====
`timescale 1ns/1ps

module int_rs
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               dispatch_valid,
    input  uop_t               dispatch_uop,
    output logic               dispatch_ready,

    input  cdb_t               cdb [CDB_WIDTH],

    output logic [PHY_IDX-1:0] rs1_phy,
    output logic [PHY_IDX-1:0] rs2_phy,
    input  logic [XLEN-1:0]    rs1_value,
    input  logic [XLEN-1:0]    rs2_value,

    output issue_t             issue,
    output logic               issue_valid
);

    //////////////////////////////////////////////////////////////////////
    // station storage
    //////////////////////////////////////////////////////////////////////

    uop_t                   entries [INTRS_DEPTH];
    logic [INTRS_DEPTH-1:0] free;
    // oldest slot, select and placement both start here
    logic [INTRS_IDX-1:0]   top;

    logic                   push_en;
    logic                   push_found;
    logic [INTRS_IDX-1:0]   push_idx;

    logic [INTRS_DEPTH-1:0] src1_ok;
    logic [INTRS_DEPTH-1:0] src2_ok;
    logic [INTRS_DEPTH-1:0] entry_ready;
    logic                   issue_en;
    logic [INTRS_IDX-1:0]   issue_idx;

    // true when any valid lane broadcasts this tag
    function automatic logic cdb_hit(input logic [PHY_IDX-1:0] tag, input cdb_t lanes [CDB_WIDTH]);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (lanes[k].valid && (lanes[k].rd_phy == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ready does not look at valid
    assign dispatch_ready = |free;
    assign push_en        = dispatch_valid && dispatch_ready;

    // first free slot at or after top
    always_comb begin
        push_idx   = top;
        push_found = 1'b0;
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            if (!push_found && free[INTRS_IDX'(top + i)]) begin
                push_idx   = INTRS_IDX'(top + i);
                push_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free <= '1;
            top  <= '0;
        end else begin
            // wakeup of stored sources
            for (int i = 0; i < INTRS_DEPTH; i++) begin
                if (!free[i] && cdb_hit(entries[i].rs1_phy, cdb)) begin
                    entries[i].rs1_valid <= 1'b1;
                end
                if (!free[i] && cdb_hit(entries[i].rs2_phy, cdb)) begin
                    entries[i].rs2_valid <= 1'b1;
                end
            end

            if (push_en) begin
                free[push_idx]    <= 1'b0;
                entries[push_idx] <= dispatch_uop;
                // a broadcast in the accepting cycle must not be missed
                entries[push_idx].rs1_valid <= dispatch_uop.rs1_valid
                                             | cdb_hit(dispatch_uop.rs1_phy, cdb);
                entries[push_idx].rs2_valid <= dispatch_uop.rs2_valid
                                             | cdb_hit(dispatch_uop.rs2_phy, cdb);
            end

            if (issue_en) begin
                free[issue_idx] <= 1'b1;
                top             <= issue_idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // select
    //////////////////////////////////////////////////////////////////////

    // stored flag, live broadcast, or a non-register operand
    always_comb begin
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            src1_ok[i] = (entries[i].op1_sel != OP1_RS1)
                       || entries[i].rs1_valid
                       || cdb_hit(entries[i].rs1_phy, cdb);
            src2_ok[i] = (entries[i].op2_sel != OP2_RS2)
                       || entries[i].rs2_valid
                       || cdb_hit(entries[i].rs2_phy, cdb);
        end
    end

    assign entry_ready = ~free & src1_ok & src2_ok;

    // oldest ready, counted from top
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = top;
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            if (!issue_en && entry_ready[INTRS_IDX'(top + i)]) begin
                issue_idx = INTRS_IDX'(top + i);
                issue_en  = 1'b1;
            end
        end
    end

    // register file lookup for the selected entry
    assign rs1_phy = entries[issue_idx].rs1_phy;
    assign rs2_phy = entries[issue_idx].rs2_phy;

    //////////////////////////////////////////////////////////////////////
    // issue register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_en;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            issue.pc        <= entries[issue_idx].pc;
            issue.fu_opcode <= entries[issue_idx].fu_opcode;
            issue.op1_sel   <= entries[issue_idx].op1_sel;
            issue.op2_sel   <= entries[issue_idx].op2_sel;
            issue.rd_phy    <= entries[issue_idx].rd_phy;
            issue.rd_arch   <= entries[issue_idx].rd_arch;
            issue.imm       <= entries[issue_idx].imm;
            issue.rob_id    <= entries[issue_idx].rob_id;
            issue.rs1_value <= rs1_value;
            issue.rs2_value <= rs2_value;
        end
    end

endmodule

// ==== source/phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic [PHY_IDX-1:0] rs1_phy,
    input  logic [PHY_IDX-1:0] rs2_phy,
    output logic [XLEN-1:0]    rs1_value,
    output logic [XLEN-1:0]    rs2_value,

    input  cdb_t               cdb [CDB_WIDTH]
);

    logic [XLEN-1:0] regs [PHY_REGS];

    // register read with same-cycle CDB bypass, lane 0 has priority
    function automatic logic [XLEN-1:0] read_port(input logic [PHY_IDX-1:0] tag);
        logic [XLEN-1:0] value;
        value = regs[tag];
        for (int k = CDB_WIDTH - 1; k >= 0; k--) begin
            if (cdb[k].valid && (cdb[k].rd_phy == tag)) begin
                value = cdb[k].value;
            end
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHY_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // highest lane first so lane 0 wins a tag conflict
            for (int k = CDB_WIDTH - 1; k >= 0; k--) begin
                if (cdb[k].valid) begin
                    regs[cdb[k].rd_phy] <= cdb[k].value;
                end
            end
        end
    end

    always_comb begin
        rs1_value = read_port(rs1_phy);
        rs2_value = read_port(rs2_phy);
    end

endmodule

// ==== source/fu_alu.sv ====
`timescale 1ns/1ps

module fu_alu
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  issue_t issue,
    input  logic   issue_valid,

    output cdb_t   cdb_alu
);

    logic [XLEN-1:0]     op1;
    logic [XLEN-1:0]     op2;
    logic [4:0]          shamt;
    logic [XLEN-1:0]     result;

    logic                valid_q;
    logic [ROB_IDX-1:0]  rob_id_q;
    logic [PHY_IDX-1:0]  rd_phy_q;
    logic [ARCH_IDX-1:0] rd_arch_q;
    logic [XLEN-1:0]     value_q;

    //////////////////////////////////////////////////////////////////////
    // operand forming
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.op1_sel)
            OP1_RS1: op1 = issue.rs1_value;
            OP1_PC:  op1 = issue.pc;
            default: op1 = '0;
        endcase
        case (issue.op2_sel)
            OP2_RS2: op2 = issue.rs2_value;
            OP2_IMM: op2 = issue.imm;
            default: op2 = '0;
        endcase
    end

    // shifts only use the low five bits
    assign shamt = op2[4:0];

    always_comb begin
        case (issue.fu_opcode)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_SLL:  result = op1 << shamt;
            ALU_SRL:  result = op1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(op1) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op1 < op2};
            default:  result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // result register, drives lane 0
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        rob_id_q  <= issue.rob_id;
        rd_phy_q  <= issue.rd_phy;
        rd_arch_q <= issue.rd_arch;
        value_q   <= result;
    end

    assign cdb_alu.valid   = valid_q;
    assign cdb_alu.rob_id  = rob_id_q;
    assign cdb_alu.rd_phy  = rd_phy_q;
    assign cdb_alu.rd_arch = rd_arch_q;
    assign cdb_alu.value   = value_q;

endmodule

// ==== source/int_issue.sv ====
`timescale 1ns/1ps

module int_issue
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic dispatch_valid,
    input  uop_t dispatch_uop,
    output logic dispatch_ready,

    input  cdb_t cdb_ext,
    output cdb_t cdb_alu
);

    // lane 0 is the ALU, lane 1 stands for the other units
    cdb_t               cdb_bus [CDB_WIDTH];

    logic [PHY_IDX-1:0] rs1_phy;
    logic [PHY_IDX-1:0] rs2_phy;
    logic [XLEN-1:0]    rs1_value;
    logic [XLEN-1:0]    rs2_value;
    issue_t             issue;
    logic               issue_valid;

    assign cdb_bus[0] = cdb_alu;
    assign cdb_bus[1] = cdb_ext;

    int_rs int_rs_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb_bus),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .issue          (issue),
        .issue_valid    (issue_valid)
    );

    phys_reg_file phys_reg_file_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .cdb       (cdb_bus)
    );

    fu_alu fu_alu_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .cdb_alu     (cdb_alu)
    );

endmodule

// ==== tb/int_issue_tb_cases.svh ====
`ifndef INT_ISSUE_TB_CASES_SVH
`define INT_ISSUE_TB_CASES_SVH

// columns: op, op1 select, op2 select, pc, imm, source 1 value, source 2 value,
// wake (1 = broadcast after dispatch), rnd (1 = values from the LCG)
typedef struct {
    alu_op_e         op;
    op1_sel_e        sel1;
    op2_sel_e        sel2;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    logic            wake;
    logic            rnd;
} case_t;

localparam int NUM_CASES = 16;

case_t cases [NUM_CASES];

task automatic load_cases();
    // every ALU op, sources preloaded
    cases[0]  = '{ALU_ADD,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h5,        32'h7,  0, 0};
    cases[1]  = '{ALU_SUB,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h3,        32'ha,  0, 0};
    cases[2]  = '{ALU_AND,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h0,        32'h0,  0, 1};
    cases[3]  = '{ALU_OR,   OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h0,        32'h0,  0, 1};
    cases[4]  = '{ALU_XOR,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h0,        32'h0,  0, 1};
    // shift amount takes only the low five bits
    cases[5]  = '{ALU_SLL,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h1,        32'h23, 0, 0};
    cases[6]  = '{ALU_SRL,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h8000_0000, 32'h4, 0, 0};
    cases[7]  = '{ALU_SRA,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h8000_0000, 32'h4, 0, 0};
    cases[8]  = '{ALU_SLT,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'hffff_ffff, 32'h1, 0, 0};
    cases[9]  = '{ALU_SLTU, OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'hffff_ffff, 32'h1, 0, 0};
    // operand selects
    cases[10] = '{ALU_ADD,  OP1_PC,   OP2_IMM,  32'h1000, 32'h24, 32'h0,        32'h0,  0, 0};
    cases[11] = '{ALU_OR,   OP1_ZERO, OP2_IMM,  32'h0,    32'h5a, 32'h0,        32'h0,  0, 0};
    cases[12] = '{ALU_SUB,  OP1_RS1,  OP2_ZERO, 32'h0,    32'h0,  32'h0,        32'h0,  0, 1};
    // sources arrive after dispatch
    cases[13] = '{ALU_ADD,  OP1_RS1,  OP2_IMM,  32'h0,    32'h10, 32'h0,        32'h0,  1, 1};
    cases[14] = '{ALU_XOR,  OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h0,        32'h0,  1, 1};
    cases[15] = '{ALU_SLTU, OP1_RS1,  OP2_RS2,  32'h0,    32'h0,  32'h0,        32'h0,  1, 1};
endtask

`endif

// ==== tb/int_issue_tb.sv ====
`timescale 1ns/1ps

module int_issue_tb
    import cpu_pkg::*;
();

    `include "int_issue_tb_cases.svh"

    localparam int LIMIT = NUM_CASES * 20 + 100;

    logic clk;
    logic rst;
    logic dispatch_valid;
    uop_t dispatch_uop;
    logic dispatch_ready;
    cdb_t cdb_ext;
    cdb_t cdb_alu;

    logic [31:0] lcg_state = 32'h783d_a533;
    int          cycles = 0;
    cdb_t        results [16];
    logic        seen [16];
    int          seen_cycle [16];

    int_issue int_issue_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb_ext        (cdb_ext),
        .cdb_alu        (cdb_alu)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run did not finish within %0d cycles", LIMIT);
            stop_failed();
        end
    end

    // results come back in any order, keyed by rob id
    always @(negedge clk) begin
        if (!rst && cdb_alu.valid) begin
            results[cdb_alu.rob_id]    = cdb_alu;
            seen[cdb_alu.rob_id]       = 1'b1;
            seen_cycle[cdb_alu.rob_id] = cycles;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic uop_t build_uop(input case_t c, input int rob, input int r1,
                                       input int r2, input int rd);
        uop_t u;
        u.pc        = c.pc;
        u.fu_opcode = c.op;
        u.op1_sel   = c.sel1;
        u.op2_sel   = c.sel2;
        u.rd_phy    = PHY_IDX'(rd);
        u.rd_arch   = ARCH_IDX'(rd);
        u.rs1_phy   = PHY_IDX'(r1);
        // ready flags only for register sources already written
        u.rs1_valid = !c.wake && (c.sel1 == OP1_RS1);
        u.rs2_phy   = PHY_IDX'(r2);
        u.rs2_valid = !c.wake && (c.sel2 == OP2_RS2);
        u.imm       = c.imm;
        u.rob_id    = ROB_IDX'(rob);
        return u;
    endfunction

    function automatic cdb_t expect_cdb(input case_t c, input uop_t u);
        cdb_t            e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = (c.sel1 == OP1_RS1) ? c.v1 : (c.sel1 == OP1_PC) ? c.pc : '0;
        b = (c.sel2 == OP2_RS2) ? c.v2 : (c.sel2 == OP2_IMM) ? c.imm : '0;
        e.valid   = 1'b1;
        e.rob_id  = u.rob_id;
        e.rd_phy  = u.rd_phy;
        e.rd_arch = u.rd_arch;
        e.value   = ref_alu(c.op, a, b);
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drivers and checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_failed();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_cdb(input cdb_t got, input cdb_t exp);
        if (got.value !== exp.value) begin
            $display("Error cdb_alu.value got %h expected %h", got.value, exp.value);
            stop_failed();
        end
        if (got.rd_phy !== exp.rd_phy) begin
            $display("Error cdb_alu.rd_phy got %h expected %h", got.rd_phy, exp.rd_phy);
            stop_failed();
        end
        if (got.rd_arch !== exp.rd_arch) begin
            $display("Error cdb_alu.rd_arch got %h expected %h", got.rd_arch, exp.rd_arch);
            stop_failed();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error dispatch_ready got %h expected %h", got, exp);
            stop_failed();
        end
    endtask

    task automatic broadcast(input logic [PHY_IDX-1:0] tag, input logic [XLEN-1:0] value);
        @(negedge clk);
        cdb_ext = '{valid: 1'b1, rob_id: '0, rd_phy: tag, rd_arch: '0, value: value};
        @(negedge clk);
        cdb_ext.valid = 1'b0;
    endtask

    // source 2 goes first so its stored ready flag has to hold
    task automatic preload(input case_t c, input uop_t u);
        if (c.sel2 == OP2_RS2) begin
            broadcast(u.rs2_phy, c.v2);
        end
        if (c.sel1 == OP1_RS1) begin
            broadcast(u.rs1_phy, c.v1);
        end
    endtask

    // holds valid until the station takes the micro-op
    task automatic dispatch(input uop_t u, output int acc);
        logic taken;
        taken = 1'b0;
        @(negedge clk);
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        while (!taken) begin
            taken = dispatch_ready;
            @(negedge clk);
        end
        acc            = cycles;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_result(input int rob);
        int n;
        n = 0;
        while (!seen[rob]) begin
            if (n == 40) begin
                $display("no result came back for rob id %0d", rob);
                stop_failed();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic expect_none(input int rob);
        if (seen[rob]) begin
            $display("result for rob id %0d came back before its operands", rob);
            stop_failed();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        case_t c;
        case_t cy;
        uop_t  u;
        uop_t  uy;
        cdb_t  exps [9];
        int    acc;
        logic [XLEN-1:0] v;

        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        cdb_ext        = '0;
        seen           = '{default: 1'b0};
        load_cases();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (2) begin
            @(negedge clk);
            check_ready(dispatch_ready, 1'b1);
            if (cdb_alu.valid !== 1'b0) begin
                $display("Error cdb_alu.valid got %h expected %h", cdb_alu.valid, 1'b0);
                stop_failed();
            end
        end

        // table rows, one micro-op at a time
        for (int i = 0; i < NUM_CASES; i++) begin
            c = cases[i];
            if (c.rnd) begin
                c.v1 = lcg_next();
                c.v2 = lcg_next();
            end
            u    = build_uop(c, i, 2 * i + 1, 2 * i + 2, 40 + i);
            seen = '{default: 1'b0};
            if (!c.wake) begin
                preload(c, u);
            end
            dispatch(u, acc);
            if (c.wake) begin
                repeat (3) @(negedge clk);
                expect_none(i);
                preload(c, u);
            end
            wait_result(i);
            if (!c.wake && (seen_cycle[i] - acc != 2)) begin
                $display("rob id %0d took %0d cycles instead of 2", i, seen_cycle[i] - acc);
                stop_failed();
            end
            check_cdb(results[i], expect_cdb(c, u));
        end

        // dependent chain through lane 0
        seen = '{default: 1'b0};
        v    = lcg_next();
        c    = '{ALU_ADD, OP1_RS1, OP2_IMM, 32'h0, 32'h5, v, 32'h0, 1'b1, 1'b0};
        cy   = '{ALU_SUB, OP1_RS1, OP2_IMM, 32'h0, 32'h1, v + 32'h5, 32'h0, 1'b1, 1'b0};
        u    = build_uop(c, 0, 60, 0, 61);
        uy   = build_uop(cy, 1, 61, 0, 62);
        dispatch(u, acc);
        dispatch(uy, acc);
        repeat (3) @(negedge clk);
        expect_none(0);
        expect_none(1);
        broadcast(60, v);
        wait_result(0);
        wait_result(1);
        check_cdb(results[0], expect_cdb(c, u));
        check_cdb(results[1], expect_cdb(cy, uy));

        // fill all eight entries on one missing tag
        seen = '{default: 1'b0};
        v    = lcg_next();
        for (int k = 0; k < 8; k++) begin
            c       = '{alu_op_e'(k), OP1_RS1, OP2_IMM, 32'h0, 32'(k + 1), v, 32'h0, 1'b1, 1'b0};
            u       = build_uop(c, k, 63, 0, 48 + k);
            exps[k] = expect_cdb(c, u);
            dispatch(u, acc);
        end
        check_ready(dispatch_ready, 1'b0);
        c       = '{ALU_ADD, OP1_PC, OP2_IMM, lcg_next(), lcg_next(), 32'h0, 32'h0, 1'b0, 1'b0};
        u       = build_uop(c, 8, 0, 0, 56);
        exps[8] = expect_cdb(c, u);
        fork
            dispatch(u, acc);
            begin
                repeat (3) @(negedge clk);
                for (int k = 0; k < 9; k++) begin
                    expect_none(k);
                end
                broadcast(63, v);
            end
        join
        for (int k = 0; k < 9; k++) begin
            wait_result(k);
            check_cdb(results[k], exps[k]);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== int_issue.f ====
+incdir+tb
source/cpu_pkg.sv
source/int_rs.sv
source/phys_reg_file.sv
source/fu_alu.sv
source/int_issue.sv
tb/int_issue_tb.sv

// ==== Bender.yml ====
package:
  name: int_issue

sources:
  - source/cpu_pkg.sv
  - source/int_rs.sv
  - source/phys_reg_file.sv
  - source/fu_alu.sv
  - source/int_issue.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/int_issue_tb.sv
